/* hdl/cache_bus_pkg.sv */
package cache_bus_pkg;

	// ==================================================
	// basic bus fields
	// ==================================================

	// byte address as seen by both ports
	typedef logic [31:0] adr_t;
	// one cache line holds 16 bytes
	typedef logic [127:0] line_data_t;
	// one enable bit per byte of a line
	typedef logic [15:0] byte_sel_t;

	// operations carried by the update port
	typedef enum logic [1:0] {
		OP_LOAD,
		OP_WRITE,
		OP_INVAL
	} upd_op_e;

	// ==================================================
	// read port
	// ==================================================

	typedef struct packed {
		logic stb;
		adr_t adr;
	} rd_req_t;

	typedef struct packed {
		logic       ack;
		logic       hit;
		line_data_t dat;
	} rd_rsp_t;

	// ==================================================
	// update port
	// ==================================================

	typedef struct packed {
		logic       stb;
		upd_op_e    op;
		adr_t       adr;
		byte_sel_t  sel;
		line_data_t dat;
	} upd_req_t;

	// hit is only meaningful in the ack cycle
	typedef struct packed {
		logic ack;
		logic hit;
	} upd_rsp_t;

endpackage

/* hdl/cache_geom_pkg.sv */
package cache_geom_pkg;

	// ==================================================
	// geometry
	// ==================================================

	// four ways per set, 16 bytes per line
	localparam int WAYS = 4;
	localparam int OFFSET_BITS = 4;

	// the tag keeps every address bit above the line offset, index bits included,
	// so none of these types change with the number of sets
	typedef logic [$bits(cache_bus_pkg::adr_t)-OFFSET_BITS-1:0] tag_t;

	typedef logic [$clog2(WAYS)-1:0] way_idx_t;
	// one bit per way, bit 0 is the newest fill
	typedef logic [WAYS-1:0] way_mask_t;

	// contents of one way
	typedef struct packed {
		tag_t                     tag;
		logic                     modified;
		cache_bus_pkg::line_data_t data;
	} way_line_t;

	// all ways of one set, read and written as a single word
	typedef way_line_t [WAYS-1:0] set_line_t;

	// update sequencer states
	typedef enum logic [2:0] {
		ST_SWEEP,
		ST_IDLE,
		ST_LOOKUP,
		ST_COMPARE,
		ST_COMMIT
	} fsm_state_e;

endpackage

/* hdl/way_match.sv */
module way_match (
	input  cache_bus_pkg::adr_t       adr,
	input  cache_geom_pkg::set_line_t set,
	input  cache_geom_pkg::way_mask_t valid,
	output cache_geom_pkg::way_mask_t hit_mask,
	output logic                      hit,
	output cache_geom_pkg::way_idx_t  hit_way
);
	import cache_geom_pkg::*;

	tag_t adr_tag;

	// the tag is everything above the line offset
	assign adr_tag = tag_t'(adr >> OFFSET_BITS);

	// ==================================================
	// compare and encode
	// ==================================================

	// a way only matches while its valid bit is set
	always_comb begin
		for (int w = 0; w < WAYS; w++) begin
			hit_mask[w] = valid[w] && (set[w].tag == adr_tag);
		end
	end

	assign hit = |hit_mask;

	// scan from the top so the lowest matching way wins
	always_comb begin
		hit_way = '0;
		for (int w = WAYS - 1; w >= 0; w--) begin
			if (hit_mask[w])
				hit_way = way_idx_t'(w);
		end
	end

endmodule

/* hdl/line_merge.sv */
module line_merge (
	input  logic                      wclk,
	input  cache_bus_pkg::upd_req_t   req,
	input  cache_geom_pkg::set_line_t cur_set,
	input  cache_geom_pkg::way_mask_t cur_valid,
	input  cache_geom_pkg::way_mask_t hit_mask,
	output cache_geom_pkg::set_line_t new_set,
	output cache_geom_pkg::way_mask_t new_valid
);
	import cache_bus_pkg::*;
	import cache_geom_pkg::*;

	way_mask_t first_hit;
	set_line_t merged_set;
	way_mask_t merged_valid;

	// isolate the lowest set bit, duplicate tags resolve to the lower way
	assign first_hit = hit_mask & ((~hit_mask) + way_mask_t'(1));

	// ==================================================
	// per operation merge
	// ==================================================

	// a miss falls through every branch and leaves the set as it was read
	always_comb begin
		merged_set   = cur_set;
		merged_valid = cur_valid;
		case (req.op)
			OP_LOAD: begin
				// fill order shift, the oldest way drops off the end
				for (int w = WAYS - 1; w > 0; w--) begin
					merged_set[w] = cur_set[w-1];
				end
				merged_set[0].tag      = tag_t'(req.adr >> OFFSET_BITS);
				merged_set[0].modified = 1'b0;
				merged_set[0].data     = req.dat;
				merged_valid = {cur_valid[WAYS-2:0], 1'b1};
			end
			OP_WRITE: begin
				for (int w = 0; w < WAYS; w++) begin
					if (first_hit[w]) begin
						merged_set[w].modified = 1'b1;
						// only the selected bytes take the new data
						for (int b = 0; b < $bits(byte_sel_t); b++) begin
							if (req.sel[b])
								merged_set[w].data[b*8 +: 8] = req.dat[b*8 +: 8];
						end
					end
				end
			end
			OP_INVAL: begin
				// line contents stay, only the valid bit goes
				merged_valid = cur_valid & ~first_hit;
			end
		endcase
	end

	// registered so the commit cycle writes a settled value
	always_ff @(posedge wclk) begin
		new_set   <= merged_set;
		new_valid <= merged_valid;
	end

endmodule

/* hdl/set_store.sv */
module set_store #(
	parameter int SETS = 64
) (
	input  logic                      wclk,
	input  logic [$clog2(SETS)-1:0]   rd_index,
	output cache_geom_pkg::set_line_t rd_set,
	output cache_geom_pkg::way_mask_t rd_valid,
	input  logic [$clog2(SETS)-1:0]   upd_index,
	output cache_geom_pkg::set_line_t upd_set,
	output cache_geom_pkg::way_mask_t upd_valid,
	input  logic                      wr_en,
	input  logic [$clog2(SETS)-1:0]   wr_index,
	input  cache_geom_pkg::set_line_t wr_set,
	input  cache_geom_pkg::way_mask_t wr_valid
);
	import cache_geom_pkg::*;

	// ==================================================
	// storage
	// ==================================================

	// tags, modified flags and data of every way, one word per set
	set_line_t set_mem [SETS];

	// valid bits live apart so the sweep can clear them without touching the lines
	way_mask_t valid_mem [SETS];

	// both memories share the single write port
	always_ff @(posedge wclk) begin
		if (wr_en) begin
			set_mem[wr_index]   <= wr_set;
			valid_mem[wr_index] <= wr_valid;
		end
	end

	// ==================================================
	// read ports
	// ==================================================

	// port A serves the read pipeline
	// a read of the set written in the same cycle returns the old contents
	always_ff @(posedge wclk) begin
		rd_set   <= set_mem[rd_index];
		rd_valid <= valid_mem[rd_index];
	end

	// port B serves the update sequencer, same one cycle latency as port A
	always_ff @(posedge wclk) begin
		upd_set   <= set_mem[upd_index];
		upd_valid <= valid_mem[upd_index];
	end

endmodule

/* hdl/sweep_counter.sv */
module sweep_counter #(
	parameter int SETS = 64
) (
	input  logic                    wclk,
	input  logic                    rst,
	input  logic                    en,
	output logic [$clog2(SETS)-1:0] index,
	output logic                    done
);
	localparam int IDX_BITS = $clog2(SETS);
	localparam logic [IDX_BITS-1:0] LAST = IDX_BITS'(SETS - 1);

	// ==================================================
	// set index walk
	// ==================================================

	// one set per cycle, the index wraps back to zero after the last set
	always_ff @(posedge wclk) begin
		if (rst)
			index <= '0;
		else if (en)
			index <= index + 1'b1;
	end

	// done marks the cycle in which the last set is being cleared
	assign done = en & (index == LAST);

endmodule

/* hdl/update_fsm.sv */
module update_fsm #(
	parameter int SETS = 64
) (
	input  logic                       wclk,
	input  logic                       rst,
	input  cache_bus_pkg::upd_req_t    upd_req,
	output cache_bus_pkg::upd_rsp_t    upd_rsp,
	output logic                       ready,
	output logic                       sweep_en,
	input  logic [$clog2(SETS)-1:0]    sweep_index,
	input  logic                       sweep_done,
	output logic [$clog2(SETS)-1:0]    upd_index,
	input  cache_geom_pkg::set_line_t  new_set,
	input  cache_geom_pkg::way_mask_t  new_valid,
	input  cache_geom_pkg::way_mask_t  hit_mask,
	output logic                       wr_en,
	output logic [$clog2(SETS)-1:0]    wr_index,
	output cache_geom_pkg::set_line_t  wr_set,
	output cache_geom_pkg::way_mask_t  wr_valid,
	output cache_bus_pkg::upd_req_t    req_q
);
	import cache_bus_pkg::*;
	import cache_geom_pkg::*;

	localparam int IDX_BITS = $clog2(SETS);

	fsm_state_e state;
	fsm_state_e state_nxt;
	logic       commit;

	// ==================================================
	// state register and request latch
	// ==================================================

	// reset parks the machine in the sweep so the valid store is cleared first
	always_ff @(posedge wclk) begin
		if (rst)
			state <= ST_SWEEP;
		else
			state <= state_nxt;
	end

	// the request is held for the three cycles of lookup, compare and commit
	always_ff @(posedge wclk) begin
		if (state == ST_IDLE && upd_req.stb)
			req_q <= upd_req;
	end

	// every update takes the same fixed path, there is no early exit on a miss
	always_comb begin
		state_nxt = state;
		case (state)
			ST_SWEEP:   if (sweep_done) state_nxt = ST_IDLE;
			ST_IDLE:    if (upd_req.stb) state_nxt = ST_LOOKUP;
			ST_LOOKUP:  state_nxt = ST_COMPARE;
			ST_COMPARE: state_nxt = ST_COMMIT;
			ST_COMMIT:  state_nxt = ST_IDLE;
			default:    state_nxt = ST_SWEEP;
		endcase
	end

	// ==================================================
	// set store control
	// ==================================================

	assign ready    = (state != ST_SWEEP);
	assign sweep_en = (state == ST_SWEEP);
	assign commit   = (state == ST_COMMIT);

	// in idle the port B address comes straight from the strobe so the set is
	// back in ST_LOOKUP, afterwards the latched address keeps it stable
	assign upd_index = (state == ST_IDLE) ? upd_req.adr[OFFSET_BITS +: IDX_BITS]
	                                      : req_q.adr[OFFSET_BITS +: IDX_BITS];

	// the sweep only needs the valid bits cleared, the set payload is don't care
	assign wr_en    = sweep_en | commit;
	assign wr_index = sweep_en ? sweep_index : req_q.adr[OFFSET_BITS +: IDX_BITS];
	assign wr_set   = new_set;
	assign wr_valid = sweep_en ? '0 : new_valid;

	// a load always reports a hit, write and invalidate report the tag compare
	always_comb begin
		upd_rsp.ack = commit;
		upd_rsp.hit = commit & ((req_q.op == OP_LOAD) | (|hit_mask));
	end

	// the requester may only strobe while the machine waits in idle
	a_stb_spacing: assert property (@(posedge wclk) disable iff (rst)
		upd_req.stb |-> state == ST_IDLE);

	// every ack goes back to a strobe exactly three cycles earlier
	a_ack_latency: assert property (@(posedge wclk) disable iff (rst)
		upd_rsp.ack |-> $past(upd_req.stb, 3));

endmodule

/* hdl/read_pipe.sv */
module read_pipe #(
	parameter int SETS = 64
) (
	input  logic                      wclk,
	input  logic                      rst,
	input  logic                      ready,
	input  cache_bus_pkg::rd_req_t    req,
	output logic [$clog2(SETS)-1:0]   rd_index,
	input  cache_geom_pkg::set_line_t rd_set,
	input  cache_geom_pkg::way_mask_t rd_valid,
	output cache_bus_pkg::rd_rsp_t    rsp
);
	import cache_bus_pkg::*;
	import cache_geom_pkg::*;

	localparam int IDX_BITS = $clog2(SETS);

	logic       stb_q;
	logic       live_q;
	adr_t       adr_q;
	logic       hit;
	way_idx_t   hit_way;
	logic       ack_q;
	logic       hit_q;
	line_data_t dat_q;

	// ==================================================
	// stage one, set index out and request held
	// ==================================================

	assign rd_index = req.adr[OFFSET_BITS +: IDX_BITS];

	// live_q remembers whether the valid store was already swept at strobe time
	always_ff @(posedge wclk) begin
		if (rst) begin
			stb_q  <= 1'b0;
			live_q <= 1'b0;
		end else begin
			stb_q  <= req.stb;
			live_q <= ready;
		end
	end

	always_ff @(posedge wclk) begin
		adr_q <= req.adr;
	end

	// ==================================================
	// stage two, compare and respond
	// ==================================================

	way_match i_match (
		.adr(adr_q), .set(rd_set), .valid(rd_valid),
		.hit_mask(), .hit(hit), .hit_way(hit_way)
	);

	always_ff @(posedge wclk) begin
		if (rst) begin
			ack_q <= 1'b0;
			hit_q <= 1'b0;
		end else begin
			ack_q <= stb_q;
			hit_q <= stb_q & live_q & hit;
		end
	end

	// data reads as zero on a miss
	always_ff @(posedge wclk) begin
		dat_q <= (stb_q & live_q & hit) ? rd_set[hit_way].data : '0;
	end

	assign rsp = '{ack: ack_q, hit: hit_q, dat: dat_q};

	// each read strobe is answered two cycles later without exception
	a_rd_latency: assert property (@(posedge wclk) disable iff (rst)
		req.stb |-> ##2 rsp.ack);

endmodule

/* hdl/cache_top.sv */
module cache_top #(
	parameter int SETS = 64
) (
	input  logic                    wclk,
	input  logic                    rst,
	input  cache_bus_pkg::rd_req_t  rd_req,
	output cache_bus_pkg::rd_rsp_t  rd_rsp,
	input  cache_bus_pkg::upd_req_t upd_req,
	output cache_bus_pkg::upd_rsp_t upd_rsp,
	output logic                    ready
);
	import cache_bus_pkg::*;
	import cache_geom_pkg::*;

	localparam int IDX_BITS = $clog2(SETS);

	// ==================================================
	// interconnect
	// ==================================================

	// sweep counter handshake
	logic                sweep_en;
	logic                sweep_done;
	logic [IDX_BITS-1:0] sweep_index;

	// read lookup path, port A of the set store
	logic [IDX_BITS-1:0] rd_index;
	set_line_t           rd_set;
	way_mask_t           rd_valid;

	// update lookup path, port B of the set store
	logic [IDX_BITS-1:0] upd_index;
	set_line_t           upd_set;
	way_mask_t           upd_valid;
	way_mask_t           upd_hit_mask;
	upd_req_t            req_q;

	// merged set coming back from line_merge
	set_line_t new_set;
	way_mask_t new_valid;

	// single write port
	logic                wr_en;
	logic [IDX_BITS-1:0] wr_index;
	set_line_t           wr_set;
	way_mask_t           wr_valid;

	// ==================================================
	// instances
	// ==================================================

	update_fsm #(.SETS(SETS)) i_fsm (
		.wclk(wclk), .rst(rst),
		.upd_req(upd_req), .upd_rsp(upd_rsp), .ready(ready),
		.sweep_en(sweep_en), .sweep_index(sweep_index), .sweep_done(sweep_done),
		.upd_index(upd_index),
		.new_set(new_set), .new_valid(new_valid), .hit_mask(upd_hit_mask),
		.wr_en(wr_en), .wr_index(wr_index), .wr_set(wr_set), .wr_valid(wr_valid),
		.req_q(req_q)
	);

	sweep_counter #(.SETS(SETS)) i_sweep (
		.wclk(wclk), .rst(rst), .en(sweep_en), .index(sweep_index), .done(sweep_done)
	);

	set_store #(.SETS(SETS)) i_store (
		.wclk(wclk),
		.rd_index(rd_index), .rd_set(rd_set), .rd_valid(rd_valid),
		.upd_index(upd_index), .upd_set(upd_set), .upd_valid(upd_valid),
		.wr_en(wr_en), .wr_index(wr_index), .wr_set(wr_set), .wr_valid(wr_valid)
	);

	// tag compare for the update path, only the mask is needed here
	way_match i_upd_match (
		.adr(req_q.adr), .set(upd_set), .valid(upd_valid),
		.hit_mask(upd_hit_mask), .hit(), .hit_way()
	);

	line_merge i_merge (
		.wclk(wclk), .req(req_q), .cur_set(upd_set), .cur_valid(upd_valid),
		.hit_mask(upd_hit_mask), .new_set(new_set), .new_valid(new_valid)
	);

	read_pipe #(.SETS(SETS)) i_read (
		.wclk(wclk), .rst(rst), .ready(ready), .req(rd_req),
		.rd_index(rd_index), .rd_set(rd_set), .rd_valid(rd_valid), .rsp(rd_rsp)
	);

endmodule

/* tests/cache_model.svh */
`ifndef CACHE_MODEL_SVH
`define CACHE_MODEL_SVH

// ==================================================
// reference model of the cache contents
// ==================================================

// way 0 always holds the newest fill and way WAYS-1 the oldest
tag_t       ref_tag   [SETS][WAYS];
line_data_t ref_data  [SETS][WAYS];
logic       ref_valid [SETS][WAYS];

// the sweep after reset leaves every way of every set invalid
function automatic void clear_model();
	for (int s = 0; s < SETS; s++) begin
		for (int w = 0; w < WAYS; w++) begin
			ref_valid[s][w] = 1'b0;
		end
	end
endfunction

// set index is the address bits right above the 16 byte offset
function automatic int set_of(adr_t adr);
	return int'((adr >> 4) % SETS);
endfunction

// lowest valid way holding the tag, or -1 when the line is absent
function automatic int find_way(adr_t adr);
	int s;
	s = set_of(adr);
	for (int w = 0; w < WAYS; w++) begin
		if (ref_valid[s][w] && ref_tag[s][w] == tag_t'(adr >> 4))
			return w;
	end
	return -1;
endfunction

// a read returns the line of the lowest matching way and zero data on a miss
function automatic rd_rsp_t expect_read(adr_t adr);
	rd_rsp_t r;
	int      w;
	w = find_way(adr);
	r.ack = 1'b1;
	r.hit = (w >= 0);
	r.dat = '0;
	if (w >= 0)
		r.dat = ref_data[set_of(adr)][w];
	return r;
endfunction

// applies one update and returns the response the port should give for it
function automatic upd_rsp_t apply_update(upd_op_e op, adr_t adr, byte_sel_t sel,
		line_data_t dat);
	upd_rsp_t r;
	int       s;
	int       w;
	s = set_of(adr);
	w = find_way(adr);
	r.ack = 1'b1;
	r.hit = (op == OP_LOAD) || (w >= 0);
	if (op == OP_LOAD) begin
		// every way moves one step older and the oldest is lost
		for (int k = WAYS - 1; k > 0; k--) begin
			ref_tag[s][k]   = ref_tag[s][k-1];
			ref_data[s][k]  = ref_data[s][k-1];
			ref_valid[s][k] = ref_valid[s][k-1];
		end
		ref_tag[s][0]   = tag_t'(adr >> 4);
		ref_data[s][0]  = dat;
		ref_valid[s][0] = 1'b1;
	end else if (op == OP_WRITE && w >= 0) begin
		for (int b = 0; b < 16; b++) begin
			if (sel[b])
				ref_data[s][w][b*8 +: 8] = dat[b*8 +: 8];
		end
	end else if (op == OP_INVAL && w >= 0) begin
		ref_valid[s][w] = 1'b0;
	end
	return r;
endfunction

`endif

/* tests/tb_cache_top.sv */
module tb_cache_top;
	timeunit 1ns;
	timeprecision 1ps;

	import cache_bus_pkg::*;
	import cache_geom_pkg::*;

	localparam int SETS = 64;
	// an update acks three cycles after its strobe, so this leaves plenty of margin
	localparam int ACK_TIMEOUT = 20;
	localparam int READY_TIMEOUT = SETS + 20;

	logic     wclk;
	logic     rst;
	rd_req_t  rd_req;
	rd_rsp_t  rd_rsp;
	upd_req_t upd_req;
	upd_rsp_t upd_rsp;
	logic     ready;

	logic [31:0] lfsr;
	int          errors;
	int          checks;
	int          test_errors;
	int          tests_run;
	string       test_name;
	// addresses of the next back-to-back read burst
	adr_t        burst_q [$];

	`include "cache_model.svh"

	cache_top #(.SETS(SETS)) i_dut (
		.wclk(wclk), .rst(rst),
		.rd_req(rd_req), .rd_rsp(rd_rsp),
		.upd_req(upd_req), .upd_rsp(upd_rsp),
		.ready(ready)
	);

	initial begin
		wclk = 1'b0;
		forever #5 wclk = ~wclk;
	end

	// the run ends here if the sequence below hangs somewhere
	initial begin
		#200_000;
		$display("simulation stopped by the watchdog before the sequence finished");
		$display("test failed");
		$finish;
	end

	// ==================================================
	// random numbers
	// ==================================================

	// 32 bit Fibonacci LFSR with taps 32, 22, 2 and 1
	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// one LFSR step per bit, the newest bit lands at the bottom
	task automatic take_bits(input int n, output logic [127:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[126:0], lfsr[0]};
		end
	endtask

	// small address pool, four sets and eight tags each, so lines collide often
	task automatic pool_adr(output adr_t adr);
		logic [127:0] hi;
		logic [127:0] idx;
		logic [127:0] off;
		take_bits(3, hi);
		take_bits(2, idx);
		take_bits(4, off);
		adr = {19'h0, hi[2:0], 4'h0, idx[1:0], off[3:0]};
	endtask

	// ==================================================
	// bookkeeping and compare tasks
	// ==================================================

	task automatic start_test(input string name);
		test_name   = name;
		test_errors = 0;
		tests_run++;
	endtask

	task automatic finish_test();
		$display("test %0d %s: %0d errors", tests_run, test_name, test_errors);
	endtask

	task automatic check_rd_rsp(input rd_rsp_t got, input rd_rsp_t exp, input string what);
		checks++;
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s got ack/hit/dat %b/%b/%h expected %b/%b/%h",
				$time, what, got.ack, got.hit, got.dat, exp.ack, exp.hit, exp.dat);
			errors++;
			test_errors++;
		end
	endtask

	task automatic check_upd_rsp(input upd_rsp_t got, input upd_rsp_t exp, input string what);
		checks++;
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s got ack/hit %b/%b expected %b/%b",
				$time, what, got.ack, got.hit, exp.ack, exp.hit);
			errors++;
			test_errors++;
		end
	endtask

	// ==================================================
	// bus drivers
	// ==================================================

	// reads go out on consecutive cycles and each ack must show up two cycles
	// after its strobe, the cycles around the burst must stay quiet
	// no update is in flight here, so the update ack must stay low as well
	task automatic read_burst();
		rd_rsp_t exp [$];
		int      n;
		n = burst_q.size();
		foreach (burst_q[i])
			exp.push_back(expect_read(burst_q[i]));
		for (int k = 0; k < n + 3; k++) begin
			@(posedge wclk);
			if (k < n)
				rd_req <= '{stb: 1'b1, adr: burst_q[k]};
			else
				rd_req <= '{stb: 1'b0, adr: '0};
			@(negedge wclk);
			if (k >= 2 && k < n + 2) begin
				check_rd_rsp(rd_rsp, exp[k-2], $sformatf("read of %h", burst_q[k-2]));
			end else if (rd_rsp.ack !== 1'b0) begin
				$display("CHECK FAILED at %0t: read ack outside the two cycle slot", $time);
				errors++;
				test_errors++;
			end
			if (upd_rsp.ack !== 1'b0) begin
				$display("CHECK FAILED at %0t: update ack outside its single cycle slot",
					$time);
				errors++;
				test_errors++;
			end
		end
		burst_q.delete();
	endtask

	// one strobe, then the ack is awaited and must come exactly three cycles later
	task automatic run_update(input upd_op_e op, input adr_t adr, input byte_sel_t sel,
			input line_data_t dat);
		upd_rsp_t exp;
		int       lat;
		@(posedge wclk);
		upd_req <= '{stb: 1'b1, op: op, adr: adr, sel: sel, dat: dat};
		@(negedge wclk);
		lat = 0;
		while (upd_rsp.ack !== 1'b1 && lat < ACK_TIMEOUT) begin
			@(posedge wclk);
			upd_req.stb <= 1'b0;
			@(negedge wclk);
			lat++;
			// ready stays high through lookup, compare and commit
			if (ready !== 1'b1) begin
				$display("CHECK FAILED at %0t: ready low while update of %h is in flight",
					$time, adr);
				errors++;
				test_errors++;
			end
		end
		if (upd_rsp.ack !== 1'b1) begin
			$display("update of %h never acknowledged within %0d cycles", adr, ACK_TIMEOUT);
			errors++;
			test_errors++;
		end else begin
			checks++;
			if (lat != 3) begin
				$display("CHECK FAILED at %0t: update ack %0d cycles after strobe, expected 3",
					$time, lat);
				errors++;
				test_errors++;
			end
			exp = apply_update(op, adr, sel, dat);
			check_upd_rsp(upd_rsp, exp, $sformatf("%s of %h", op.name(), adr));
		end
	endtask

	task automatic wait_ready();
		int n;
		n = 0;
		@(negedge wclk);
		while (ready !== 1'b1 && n < READY_TIMEOUT) begin
			@(negedge wclk);
			n++;
		end
		if (ready !== 1'b1) begin
			$display("ready still low %0d cycles after reset", READY_TIMEOUT);
			errors++;
			test_errors++;
		end
	endtask

	// ==================================================
	// test sequence
	// ==================================================

	initial begin
		adr_t         a;
		adr_t         b;
		adr_t         set_adrs [5];
		logic [127:0] v;
		logic [127:0] sel;
		logic [127:0] dat;
		int           n;
		rst         = 1'b1;
		rd_req      = '0;
		upd_req     = '0;
		lfsr        = 32'h9a1c6538;
		errors      = 0;
		checks      = 0;
		tests_run   = 0;
		test_errors = 0;
		clear_model();
		repeat (3) @(posedge wclk);
		rst <= 1'b0;

		// reads during the sweep and right after it all miss
		start_test("sweep and cold reads");
		@(negedge wclk);
		if (ready !== 1'b0) begin
			$display("CHECK FAILED at %0t: ready high while the valid store is being cleared",
				$time);
			errors++;
			test_errors++;
		end
		for (int i = 0; i < 2; i++) begin
			take_bits(32, v);
			burst_q.push_back(v[31:0]);
		end
		read_burst();
		wait_ready();
		for (int i = 0; i < 4; i++) begin
			take_bits(32, v);
			burst_q.push_back(v[31:0]);
		end
		read_burst();
		finish_test();

		start_test("load then read");
		take_bits(32, v);
		a = v[31:0];
		take_bits(128, dat);
		run_update(OP_LOAD, a, '0, dat);
		burst_q.push_back(a);
		read_burst();
		finish_test();

		// byte merge into a present line, then a write that finds nothing
		start_test("write hit and miss");
		take_bits(16, sel);
		take_bits(128, dat);
		run_update(OP_WRITE, a, sel[15:0], dat);
		burst_q.push_back(a);
		read_burst();
		b = a ^ 32'h8000_0000;
		take_bits(16, sel);
		take_bits(128, dat);
		run_update(OP_WRITE, b, sel[15:0], dat);
		burst_q.push_back(b);
		read_burst();
		finish_test();

		// five tags into one set push the first one out
		start_test("eviction order");
		take_bits(32, v);
		for (int k = 0; k < 5; k++) begin
			set_adrs[k] = v[31:0] + adr_t'(k * SETS * 16);
			take_bits(128, dat);
			run_update(OP_LOAD, set_adrs[k], '0, dat);
		end
		for (int k = 0; k < 5; k++)
			burst_q.push_back(set_adrs[k]);
		read_burst();
		finish_test();

		start_test("invalidate");
		run_update(OP_INVAL, set_adrs[2], '0, '0);
		for (int k = 1; k < 5; k++)
			burst_q.push_back(set_adrs[k]);
		read_burst();
		run_update(OP_INVAL, set_adrs[0], '0, '0);
		finish_test();

		// mixed traffic, every update is followed by a read of its address
		start_test("random traffic");
		for (int i = 0; i < 300; i++) begin
			take_bits(2, v);
			pool_adr(a);
			take_bits(16, sel);
			take_bits(128, dat);
			case (v[1:0])
				2'd0: begin
					take_bits(2, v);
					n = 1 + int'(v[1:0]) % 3;
					burst_q.push_back(a);
					for (int k = 1; k < n; k++) begin
						pool_adr(b);
						burst_q.push_back(b);
					end
				end
				2'd1: run_update(OP_LOAD, a, sel[15:0], dat);
				2'd2: run_update(OP_WRITE, a, sel[15:0], dat);
				default: run_update(OP_INVAL, a, sel[15:0], dat);
			endcase
			if (burst_q.size() == 0)
				burst_q.push_back(a);
			read_burst();
		end
		finish_test();

		$display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

/* filelist.f */
+incdir+tests
hdl/cache_bus_pkg.sv
hdl/cache_geom_pkg.sv
hdl/way_match.sv
hdl/line_merge.sv
hdl/set_store.sv
hdl/sweep_counter.sv
hdl/update_fsm.sv
hdl/read_pipe.sv
hdl/cache_top.sv
tests/tb_cache_top.sv

/* Bender.yml */
package:
  name: cache_top

sources:
  - hdl/cache_bus_pkg.sv
  - hdl/cache_geom_pkg.sv
  - hdl/way_match.sv
  - hdl/line_merge.sv
  - hdl/set_store.sv
  - hdl/sweep_counter.sv
  - hdl/update_fsm.sv
  - hdl/read_pipe.sv
  - hdl/cache_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_cache_top.sv
